//--- verilog/hamming_pkg.sv
`default_nettype none

package hamming_pkg;

    // ==============================
    // Widths
    // ==============================
    localparam int max_codeword_width = 32;
    localparam int max_info_width     = 26;
    localparam int max_parity_width   = 6;

    typedef logic [max_codeword_width-1:0] codeword_t;
    typedef logic [max_info_width-1:0]     info_t;
    typedef logic [max_parity_width-1:0]   syndrome_t;   // Bit 5 is the overall check
    typedef logic [max_parity_width-2:0]   column_t;

    typedef enum logic [1:0] {
        mode_8_4   = 2'b00,
        mode_16_11 = 2'b01,
        mode_32_26 = 2'b10,
        mode_off   = 2'b11
    } mode_t;

    // Column codes are the integers from 3 up that are not powers of two
    localparam column_t h_columns [max_info_width] = '{
        5'd3,  5'd5,  5'd6,  5'd7,  5'd9,  5'd10, 5'd11, 5'd12, 5'd13,
        5'd14, 5'd15, 5'd17, 5'd18, 5'd19, 5'd20, 5'd21, 5'd22, 5'd23,
        5'd24, 5'd25, 5'd26, 5'd27, 5'd28, 5'd29, 5'd30, 5'd31
    };

    function automatic int info_bits(mode_t mode);
        case (mode)
            mode_8_4:   return 4;
            mode_16_11: return 11;
            mode_32_26: return 26;
            default:    return 0;
        endcase
    endfunction

    // Includes the overall parity bit
    function automatic int parity_bits(mode_t mode);
        case (mode)
            mode_8_4:   return 4;
            mode_16_11: return 5;
            mode_32_26: return 6;
            default:    return 0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- verilog/parity_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module parity_matrix #(
    parameter int rows = 5,
    parameter int cols = 26
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [rows*cols-1:0]   masks,
    input  wire logic [cols-1:0]        vec,
    output logic      [rows-1:0]        parity
);

    logic [rows-1:0] parity_next;

    // Each row is one GF(2) dot product of its mask with the vector
    always_comb begin : gf2_product
        for (int r = 0; r < rows; r++) begin
            parity_next[r] = ^(masks[r*cols +: cols] & vec);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            parity <= '0;
        end else begin
            parity <= parity_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/enc_stage_1.sv
`timescale 1ns/1ps
`default_nettype none

module enc_stage_1 (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    input  wire hamming_pkg::info_t     info,
    input  wire hamming_pkg::mode_t     mode,
    output logic                        out_valid,
    output hamming_pkg::codeword_t      word,
    output hamming_pkg::mode_t          out_mode
);

    import hamming_pkg::*;

    localparam int ham_rows = max_parity_width - 1;

    logic [ham_rows*max_info_width-1:0] masks;
    logic [ham_rows-1:0]                hamming;
    info_t                              info_q;

    // ==============================
    // Parity check rows per mode
    // ==============================
    always_comb begin : mask_build
        int k;
        int p;
        k = info_bits(mode);
        p = parity_bits(mode);
        masks = '0;
        for (int j = 0; j < ham_rows; j++) begin
            for (int i = 0; i < max_info_width; i++) begin
                if (j + 1 < p && i < k) begin
                    masks[j*max_info_width + i] = h_columns[i][j];
                end
            end
        end
    end

    parity_matrix #(
        .rows (ham_rows),
        .cols (max_info_width)
    ) u_parity (
        .clk    (clk),
        .rst    (rst),
        .masks  (masks),
        .vec    (info),
        .parity (hamming)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_mode  <= mode_off;
        end else begin
            out_valid <= in_valid;
            out_mode  <= mode;
        end
    end

    always_ff @(posedge clk) begin
        info_q <= info;   // Kept in step with the registered parity
    end

    // Overall bit left at zero for the next stage
    always_comb begin : place_bits
        case (out_mode)
            mode_8_4:   word = {24'b0, info_q[3:0], 1'b0, hamming[2:0]};
            mode_16_11: word = {16'b0, info_q[10:0], 1'b0, hamming[3:0]};
            mode_32_26: word = {info_q[25:0], 1'b0, hamming[4:0]};
            default:    word = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/enc_stage_2.sv
`timescale 1ns/1ps
`default_nettype none

module enc_stage_2 (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    input  wire hamming_pkg::codeword_t word,
    input  wire hamming_pkg::mode_t     mode,
    output logic                        out_valid,
    output hamming_pkg::codeword_t      codeword
);

    import hamming_pkg::*;

    codeword_t used_mask;
    codeword_t codeword_next;
    logic      overall;

    always_comb begin : insert_overall
        int k;
        int p;
        k = info_bits(mode);
        p = parity_bits(mode);
        used_mask = '0;
        for (int b = 0; b < max_codeword_width; b++) begin
            if (b < p + k) begin
                used_mask[b] = 1'b1;
            end
        end
        overall       = ^(word & used_mask);   // Covers info and Hamming bits
        codeword_next = word & used_mask;      // Pads above P+K with zeros
        if (p > 0) begin
            codeword_next[p-1] = overall;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            codeword  <= '0;
        end else begin
            out_valid <= in_valid;
            codeword  <= codeword_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dec_syndrome.sv
`timescale 1ns/1ps
`default_nettype none

module dec_syndrome (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    input  wire hamming_pkg::codeword_t codeword,
    input  wire hamming_pkg::mode_t     mode,
    output logic                        out_valid,
    output hamming_pkg::codeword_t      word,
    output hamming_pkg::mode_t          out_mode,
    output hamming_pkg::syndrome_t      syndrome
);

    import hamming_pkg::*;

    localparam int overall_row = max_parity_width - 1;

    logic [max_parity_width*max_codeword_width-1:0] masks;

    // ==============================
    // Check rows per mode
    // ==============================
    always_comb begin : mask_build
        int k;
        int p;
        k = info_bits(mode);
        p = parity_bits(mode);
        masks = '0;
        for (int j = 0; j < overall_row; j++) begin
            if (j + 1 < p) begin
                masks[j*max_codeword_width + j] = 1'b1;   // The row's own parity bit
                for (int i = 0; i < max_info_width; i++) begin
                    if (i < k && h_columns[i][j]) begin
                        masks[j*max_codeword_width + p + i] = 1'b1;
                    end
                end
            end
        end
        for (int b = 0; b < max_codeword_width; b++) begin
            if (b < p + k) begin
                masks[overall_row*max_codeword_width + b] = 1'b1;
            end
        end
    end

    parity_matrix #(
        .rows (max_parity_width),
        .cols (max_codeword_width)
    ) u_checks (
        .clk    (clk),
        .rst    (rst),
        .masks  (masks),
        .vec    (codeword),
        .parity (syndrome)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_mode  <= mode_off;
            word      <= '0;
        end else begin
            out_valid <= in_valid;
            out_mode  <= mode;
            word      <= codeword;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dec_correct.sv
`timescale 1ns/1ps
`default_nettype none

module dec_correct (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   in_valid,
    input  wire hamming_pkg::codeword_t word,
    input  wire hamming_pkg::mode_t     mode,
    input  wire hamming_pkg::syndrome_t syndrome,
    output logic                        out_valid,
    output hamming_pkg::info_t          info,
    output logic                        corrected,
    output logic                        uncorrectable
);

    import hamming_pkg::*;

    column_t   ham;
    codeword_t flip;
    codeword_t fixed;
    info_t     info_next;
    logic      single;

    assign ham = syndrome[max_parity_width-2:0];

    // ==============================
    // Error location
    // ==============================
    always_comb begin : locate
        int k;
        int p;
        k = info_bits(mode);
        p = parity_bits(mode);
        flip   = '0;
        single = 1'b0;
        if (syndrome[max_parity_width-1] && p > 0) begin
            if (ham == '0) begin
                flip[p-1] = 1'b1;   // Only the overall bit itself is wrong
                single    = 1'b1;
            end else begin
                for (int j = 0; j < max_parity_width - 1; j++) begin
                    if (j + 1 < p && ham == column_t'(1 << j)) begin
                        flip[j] = 1'b1;
                        single  = 1'b1;
                    end
                end
                // Column codes are unique, so at most one of these hits
                for (int i = 0; i < max_info_width; i++) begin
                    if (i < k && ham == h_columns[i]) begin
                        flip[p+i] = 1'b1;
                        single    = 1'b1;
                    end
                end
            end
        end
    end

    assign fixed = word ^ flip;

    always_comb begin : extract_info
        case (mode)
            mode_8_4:   info_next = {22'b0, fixed[7:4]};
            mode_16_11: info_next = {15'b0, fixed[15:5]};
            mode_32_26: info_next = fixed[31:6];
            default:    info_next = '0;
        endcase
    end

    // A nonzero syndrome that points nowhere is a double error
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid     <= 1'b0;
            info          <= '0;
            corrected     <= 1'b0;
            uncorrectable <= 1'b0;
        end else begin
            out_valid     <= in_valid;
            info          <= info_next;
            corrected     <= in_valid && single;
            uncorrectable <= in_valid && (syndrome != '0) && !single;
        end
    end

endmodule

`default_nettype wire

//--- verilog/err_counter.sv
`timescale 1ns/1ps
`default_nettype none

module err_counter #(
    parameter int count_width = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   count_clear,
    input  wire logic                   corrected,
    input  wire logic                   uncorrectable,
    output logic [count_width-1:0]      corrected_count,
    output logic [count_width-1:0]      uncorrectable_count
);

    typedef logic [count_width-1:0] count_t;

    localparam count_t count_max = '1;

    // Clear wins over an increment in the same cycle
    always_ff @(posedge clk) begin
        if (rst || count_clear) begin
            corrected_count     <= '0;
            uncorrectable_count <= '0;
        end else begin
            if (corrected && corrected_count != count_max) begin
                corrected_count <= corrected_count + 1'b1;
            end
            if (uncorrectable && uncorrectable_count != count_max) begin
                uncorrectable_count <= uncorrectable_count + 1'b1;   // Holds at the top
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/hamming_codec_top.sv
`timescale 1ns/1ps
`default_nettype none

module hamming_codec_top #(
    parameter int count_width = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    // Encoder
    input  wire logic                   enc_in_valid,
    input  wire hamming_pkg::info_t     enc_info,
    input  wire hamming_pkg::mode_t     enc_mode,
    output logic                        enc_out_valid,
    output hamming_pkg::codeword_t      enc_codeword,
    // Decoder
    input  wire logic                   dec_in_valid,
    input  wire hamming_pkg::codeword_t dec_codeword,
    input  wire hamming_pkg::mode_t     dec_mode,
    output logic                        dec_out_valid,
    output hamming_pkg::info_t          dec_info,
    output logic                        dec_corrected,
    output logic                        dec_uncorrectable,
    // Counters
    input  wire logic                   count_clear,
    output logic [count_width-1:0]      corrected_count,
    output logic [count_width-1:0]      uncorrectable_count
);

    import hamming_pkg::*;

    logic      s1_valid;
    codeword_t s1_word;
    mode_t     s1_mode;

    logic      syn_valid;
    codeword_t syn_word;
    mode_t     syn_mode;
    syndrome_t syndrome;

    // ==============================
    // Encoder path
    // ==============================
    enc_stage_1 u_enc_stage_1 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (enc_in_valid),
        .info      (enc_info),
        .mode      (enc_mode),
        .out_valid (s1_valid),
        .word      (s1_word),
        .out_mode  (s1_mode)
    );

    enc_stage_2 u_enc_stage_2 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s1_valid),
        .word      (s1_word),
        .mode      (s1_mode),
        .out_valid (enc_out_valid),
        .codeword  (enc_codeword)
    );

    // ==============================
    // Decoder path
    // ==============================
    dec_syndrome u_dec_syndrome (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dec_in_valid),
        .codeword  (dec_codeword),
        .mode      (dec_mode),
        .out_valid (syn_valid),
        .word      (syn_word),
        .out_mode  (syn_mode),
        .syndrome  (syndrome)
    );

    dec_correct u_dec_correct (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (syn_valid),
        .word          (syn_word),
        .mode          (syn_mode),
        .syndrome      (syndrome),
        .out_valid     (dec_out_valid),
        .info          (dec_info),
        .corrected     (dec_corrected),
        .uncorrectable (dec_uncorrectable)
    );

    err_counter #(
        .count_width (count_width)
    ) u_err_counter (
        .clk                 (clk),
        .rst                 (rst),
        .count_clear         (count_clear),
        .corrected           (dec_corrected),
        .uncorrectable       (dec_uncorrectable),
        .corrected_count     (corrected_count),
        .uncorrectable_count (uncorrectable_count)
    );

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real half_period  = 4.0,
    parameter int  reset_cycles = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;   // Released between rising edges
    end

endmodule

`default_nettype wire

//--- bench/tb_hamming_codec.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hamming_codec;

    import hamming_pkg::*;

    localparam int count_width  = 8;
    localparam int num_directed = 20;
    localparam int num_random   = 24;
    localparam int num_rows     = num_directed + num_random;
    localparam int pipe_latency = 2;
    localparam int cycle_limit  = num_rows * 4 + 50;

    typedef logic [count_width-1:0] count_t;

    logic      clk;
    logic      rst;
    logic      enc_in_valid;
    info_t     enc_info;
    mode_t     enc_mode;
    logic      enc_out_valid;
    codeword_t enc_codeword;
    logic      dec_in_valid;
    codeword_t dec_codeword;
    mode_t     dec_mode;
    logic      dec_out_valid;
    info_t     dec_info;
    logic      dec_corrected;
    logic      dec_uncorrectable;
    logic      count_clear;
    count_t    corrected_count;
    count_t    uncorrectable_count;

    // ==============================
    // Stimulus and expected values
    // ==============================
    mode_t     row_mode     [num_rows];
    info_t     row_info     [num_rows];
    codeword_t row_err      [num_rows];
    codeword_t exp_codeword [num_rows];
    info_t     exp_info     [num_rows];
    logic      exp_corr     [num_rows];
    logic      exp_unc      [num_rows];
    int        sent_cycle   [num_rows];

    int     cycle = 0;
    int     out_idx = 0;
    int     checks = 0;
    int     failures = 0;
    int     row_failures = 0;
    count_t exp_corr_total;
    count_t exp_unc_total;

    tb_clock_gen #(
        .half_period  (4.0),
        .reset_cycles (2)
    ) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    hamming_codec_top #(
        .count_width (count_width)
    ) dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .enc_in_valid        (enc_in_valid),
        .enc_info            (enc_info),
        .enc_mode            (enc_mode),
        .enc_out_valid       (enc_out_valid),
        .enc_codeword        (enc_codeword),
        .dec_in_valid        (dec_in_valid),
        .dec_codeword        (dec_codeword),
        .dec_mode            (dec_mode),
        .dec_out_valid       (dec_out_valid),
        .dec_info            (dec_info),
        .dec_corrected       (dec_corrected),
        .dec_uncorrectable   (dec_uncorrectable),
        .count_clear         (count_clear),
        .corrected_count     (corrected_count),
        .uncorrectable_count (uncorrectable_count)
    );

    // ==============================
    // Reference model
    // ==============================
    function automatic int code_length(mode_t m);
        case (m)
            mode_8_4:   return 8;
            mode_16_11: return 16;
            mode_32_26: return 32;
            default:    return 0;
        endcase
    endfunction

    function automatic int code_info(mode_t m);
        case (m)
            mode_8_4:   return 4;
            mode_16_11: return 11;
            mode_32_26: return 26;
            default:    return 0;
        endcase
    endfunction

    // Walks up from 3 and skips the powers of two
    function automatic int column_code(int i);
        int v;
        int seen;
        v    = 2;
        seen = -1;
        while (seen < i) begin
            v++;
            if ((v & (v - 1)) != 0) begin
                seen++;
            end
        end
        return v;
    endfunction

    function automatic codeword_t encode_ref(mode_t m, info_t data);
        codeword_t cw;
        int        k;
        int        p;
        k  = code_info(m);
        p  = code_length(m) - k;
        cw = '0;
        for (int i = 0; i < k; i++) begin
            cw[p+i] = data[i];
        end
        for (int j = 0; j < p - 1; j++) begin
            for (int i = 0; i < k; i++) begin
                if ((column_code(i) >> j) & 1) begin
                    cw[j] = cw[j] ^ data[i];
                end
            end
        end
        if (p > 0) begin
            cw[p-1] = ^cw;   // Overall bit still zero here
        end
        return cw;
    endfunction

    function automatic info_t mask_info(mode_t m, info_t data);
        info_t r;
        r = '0;
        for (int i = 0; i < code_info(m); i++) begin
            r[i] = data[i];
        end
        return r;
    endfunction

    // Info sits at bits P+K-1..P of a codeword
    function automatic info_t info_field(mode_t m, codeword_t cw);
        info_t r;
        int    k;
        int    p;
        k = code_info(m);
        p = code_length(m) - k;
        r = '0;
        for (int i = 0; i < k; i++) begin
            r[i] = cw[p+i];
        end
        return r;
    endfunction

    function automatic codeword_t bit_at(int n);
        return codeword_t'(1) << n;
    endfunction

    task automatic add_row(int r, mode_t m, info_t data, codeword_t err);
        int nflip;
        nflip           = $countones(err);
        row_mode[r]     = m;
        row_info[r]     = data;
        row_err[r]      = err;
        exp_codeword[r] = encode_ref(m, data);
        if (nflip == 2) begin
            exp_info[r] = info_field(m, exp_codeword[r] ^ err);   // Passed through uncorrected
        end else begin
            exp_info[r] = mask_info(m, data);
        end
        exp_corr[r]     = (m != mode_off) && (nflip == 1);
        exp_unc[r]      = (m != mode_off) && (nflip == 2);
    endtask

    task automatic build_table();
        mode_t     m;
        codeword_t err;
        int        r;
        int        w;
        int        a;
        int        b;
        int        nflip;
        r = 0;
        for (int mi = 0; mi < 3; mi++) begin
            m = mode_t'(mi);
            w = code_length(m);
            add_row(r,     m, '0, '0);
            add_row(r + 1, m, '1, '0);
            add_row(r + 2, m, 26'h2aa_aaaa, bit_at(w - code_info(m) - 1));   // Overall bit
            add_row(r + 3, m, 26'h155_5555, bit_at(0));
            add_row(r + 4, m, 26'h0f0_f0f3, bit_at(w - 1));
            add_row(r + 5, m, 26'h3c3_c3c3, bit_at(0) | bit_at(w - 1));
            r += 6;
        end
        add_row(r,     mode_off, 26'h1a5_5a5a, '0);
        add_row(r + 1, mode_off, '1, 32'h0000_0011);
        r += 2;
        while (r < num_rows) begin
            m     = mode_t'($urandom % 3);
            w     = code_length(m);
            a     = $urandom % w;
            b     = (a + 1 + $urandom % (w - 1)) % w;   // Never equal to a
            nflip = $urandom % 3;
            if (nflip == 0) begin
                err = '0;
            end else if (nflip == 1) begin
                err = bit_at(a);
            end else begin
                err = bit_at(a) | bit_at(b);
            end
            add_row(r, m, info_t'($urandom), err);
            r++;
        end
    endtask

    // ==============================
    // Compare tasks
    // ==============================
    task automatic codeword_check(string what, codeword_t got, codeword_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            failures++;
            row_failures++;
        end
    endtask

    task automatic info_check(string what, info_t got, info_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
            failures++;
            row_failures++;
        end
    endtask

    task automatic flag_check(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
            failures++;
            row_failures++;
        end
    endtask

    task automatic count_check(string what, count_t got, count_t exp);
        checks++;
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
            failures++;
            row_failures++;
        end
    endtask

    task automatic latency_check(int got, int exp);
        checks++;
        if (got != exp) begin
            $display("FAIL %0t: latency is %0d cycles, expected %0d", $time, got, exp);
            failures++;
            row_failures++;
        end
    endtask

    always @(posedge clk) begin : watchdog
        cycle++;
        if (cycle >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d rows out", cycle, out_idx,
                     num_rows);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Both paths have the same depth, so each row comes out on one edge
    always @(negedge clk) begin : output_monitor
        if (!rst && (enc_out_valid || dec_out_valid)) begin
            if (out_idx >= num_rows) begin
                $display("Unexpected output at %0t with no word in flight", $time);
                failures++;
            end else begin
                row_failures = 0;
                flag_check("enc_out_valid", enc_out_valid, 1'b1);
                flag_check("dec_out_valid", dec_out_valid, 1'b1);
                codeword_check("enc_codeword", enc_codeword, exp_codeword[out_idx]);
                info_check("dec_info", dec_info, exp_info[out_idx]);
                flag_check("dec_corrected", dec_corrected, exp_corr[out_idx]);
                flag_check("dec_uncorrectable", dec_uncorrectable, exp_unc[out_idx]);
                latency_check(cycle - sent_cycle[out_idx], pipe_latency);
                if (row_failures == 0) begin
                    $display("row %0d %s err %h ok", out_idx, row_mode[out_idx].name(),
                             row_err[out_idx]);
                end else begin
                    $display("row %0d %s err %h had %0d mismatches", out_idx,
                             row_mode[out_idx].name(), row_err[out_idx], row_failures);
                end
                out_idx++;
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        enc_in_valid = 1'b0;
        enc_info     = '0;
        enc_mode     = mode_off;
        dec_in_valid = 1'b0;
        dec_codeword = '0;
        dec_mode     = mode_off;
        count_clear  = 1'b0;
        void'($urandom(32'h1975_72f4));
        build_table();
        exp_corr_total = '0;
        exp_unc_total  = '0;
        for (int r = 0; r < num_rows; r++) begin
            exp_corr_total += count_t'(exp_corr[r]);
            exp_unc_total  += count_t'(exp_unc[r]);
        end

        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        row_failures = 0;
        flag_check("enc_out_valid after reset", enc_out_valid, 1'b0);
        codeword_check("enc_codeword after reset", enc_codeword, '0);
        flag_check("dec_out_valid after reset", dec_out_valid, 1'b0);
        info_check("dec_info after reset", dec_info, '0);
        flag_check("dec_corrected after reset", dec_corrected, 1'b0);
        flag_check("dec_uncorrectable after reset", dec_uncorrectable, 1'b0);
        count_check("corrected_count after reset", corrected_count, '0);
        count_check("uncorrectable_count after reset", uncorrectable_count, '0);
        $display("reset values: %0d mismatches", row_failures);

        for (int r = 0; r < num_rows; r++) begin
            enc_in_valid  = 1'b1;
            enc_info      = row_info[r];
            enc_mode      = row_mode[r];
            dec_in_valid  = 1'b1;
            dec_codeword  = exp_codeword[r] ^ row_err[r];
            dec_mode      = row_mode[r];
            sent_cycle[r] = cycle;
            @(negedge clk);
        end
        enc_in_valid = 1'b0;
        enc_info     = '0;
        dec_in_valid = 1'b0;
        dec_codeword = '0;

        while (out_idx < num_rows) begin
            @(negedge clk);
        end
        @(negedge clk);   // Counters trail the flags by one edge
        row_failures = 0;
        count_check("corrected_count", corrected_count, exp_corr_total);
        count_check("uncorrectable_count", uncorrectable_count, exp_unc_total);
        $display("counters %0d/%0d: %0d mismatches", exp_corr_total, exp_unc_total,
                 row_failures);

        count_clear = 1'b1;
        @(negedge clk);
        count_clear  = 1'b0;
        row_failures = 0;
        count_check("corrected_count after clear", corrected_count, '0);
        count_check("uncorrectable_count after clear", uncorrectable_count, '0);
        $display("counter clear: %0d mismatches", row_failures);

        $display("Rows %0d, checks %0d, failures %0d", out_idx, checks, failures);
        if (failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/hamming_pkg.sv
verilog/parity_matrix.sv
verilog/enc_stage_1.sv
verilog/enc_stage_2.sv
verilog/dec_syndrome.sv
verilog/dec_correct.sv
verilog/err_counter.sv
verilog/hamming_codec_top.sv
bench/tb_clock_gen.sv
bench/tb_hamming_codec.sv

//--- Bender.yml
package:
  name: hamming_codec

sources:
  - files:
      - verilog/hamming_pkg.sv
      - verilog/parity_matrix.sv
      - verilog/enc_stage_1.sv
      - verilog/enc_stage_2.sv
      - verilog/dec_syndrome.sv
      - verilog/dec_correct.sv
      - verilog/err_counter.sv
      - verilog/hamming_codec_top.sv
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_hamming_codec.sv
